// ==== tests/tb_model.svh ====
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////////////////////

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit taken
function automatic logic [31:0] take_bits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		lfsr_state = lfsr_next(lfsr_state);
		v = {v[30:0], lfsr_state[0]};
	end
	return v;
endfunction

////////////////////////////////////////////////////////////////////////////
// Program generator
////////////////////////////////////////////////////////////////////////////

// One instruction of the subset, or now and then one outside it
function automatic logic [31:0] make_inst();
	logic [3:0]  kind;
	logic [4:0]  rd, rs1, rs2;
	logic [11:0] imm;
	logic [11:0] off;
	logic [9:0]  f73;	// {funct7, funct3}
	kind = 4'(take_bits(4));
	rd   = 5'(take_bits(3));	// x0..x7 only
	rs1  = 5'(take_bits(3));
	rs2  = 5'(take_bits(3));
	imm  = 12'(take_bits(12));
	off  = {7'b0, 3'(take_bits(3)), 2'b00};	// Eight words, so loads hit stores
	case (kind)
		4'd0, 4'd1, 4'd2: return {imm, rs1, 3'b000, rd, 7'b0010011};	// ADDI
		4'd3, 4'd4, 4'd5, 4'd6, 4'd7: begin
			case (3'(take_bits(3)))
				3'd0:       f73 = 10'b0000000_000;	// ADD
				3'd1, 3'd6: f73 = 10'b0100000_000;	// SUB
				3'd2:       f73 = 10'b0000000_111;	// AND
				3'd3:       f73 = 10'b0000000_110;	// OR
				3'd4:       f73 = 10'b0000000_100;	// XOR
				default:    f73 = 10'b0000000_010;	// SLT
			endcase
			return {f73[9:3], rs2, rs1, f73[2:0], rd, 7'b0110011};
		end
		4'd8, 4'd9:   return {imm, 8'(take_bits(8)), rd, 7'b0110111};	// LUI
		4'd10, 4'd11: return {off, 5'd0, 3'b010, rd, 7'b0000011};	// LW from x0
		4'd12, 4'd13: return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
		default: begin
			case (2'(take_bits(2)))
				2'd0:    return {7'b0, rs2, rs1, 3'b001, rd, 7'b0110011};	// SLL
				2'd1:    return {imm, rs1, 3'b010, rd, 7'b0010011};	// SLTI
				2'd2:    return {7'b0, rs2, rs1, 3'b000, 5'b0, 7'b1100011};	// BEQ
				default: return {off, 5'd0, 3'b000, rd, 7'b0000011};	// LB
			endcase
		end
	endcase
endfunction

// No load-use interlock, so the slot after an LW gets a NOP
function automatic void make_program();
	logic after_lw;
	after_lw = 1'b0;
	for (int k = 0; k < NUM_INST; k++) begin
		prog[k]  = after_lw ? NOP : make_inst();
		after_lw = (prog[k][6:0] == 7'b0000011 && prog[k][14:12] == 3'b010);
	end
endfunction

////////////////////////////////////////////////////////////////////////////
// Instruction-level reference
////////////////////////////////////////////////////////////////////////////

// Architectural effect of one instruction, plus what WB should show for it
function automatic void ref_step(input logic [31:0] inst, output logic exp_wr_en,
	output logic [4:0] exp_rd, output logic [31:0] exp_data);
	logic [31:0] a, b;
	logic [31:0] imm_i, imm_s;
	logic [31:0] addr;
	a         = ref_regs[inst[19:15]];
	b         = ref_regs[inst[24:20]];
	imm_i     = {{20{inst[31]}}, inst[31:20]};
	imm_s     = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	exp_rd    = inst[11:7];
	exp_wr_en = 1'b0;
	exp_data  = '0;
	case (inst[6:0])
		7'b0010011: begin
			exp_wr_en = (inst[14:12] == 3'b000);	// ADDI, other funct3 unsupported
			exp_data  = a + imm_i;
		end
		7'b0110011: begin
			exp_wr_en = 1'b1;
			case ({inst[31:25], inst[14:12]})
				10'b0000000_000: exp_data = a + b;
				10'b0100000_000: exp_data = a - b;
				10'b0000000_111: exp_data = a & b;
				10'b0000000_110: exp_data = a | b;
				10'b0000000_100: exp_data = a ^ b;
				10'b0000000_010: exp_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				default:         exp_wr_en = 1'b0;
			endcase
		end
		7'b0110111: begin	// LUI
			exp_wr_en = 1'b1;
			exp_data  = {inst[31:12], 12'b0};
		end
		7'b0000011: begin
			if (inst[14:12] == 3'b010) begin	// LW
				addr      = a + imm_i;
				exp_wr_en = 1'b1;
				exp_data  = ref_dmem[addr[DMEM_AW+1:2]];
			end
		end
		7'b0100011: begin
			if (inst[14:12] == 3'b010) begin	// SW
				addr = a + imm_s;
				ref_dmem[addr[DMEM_AW+1:2]] = b;
			end
		end
		default: ;
	endcase
	if (exp_wr_en && exp_rd != 5'd0)
		ref_regs[exp_rd] = exp_data;	// x0 never changes
endfunction

`endif

// ==== tests/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import core_pkg::*; ();

	localparam int IMEM_AW  = 6;
	localparam int DMEM_AW  = 6;
	localparam int NUM_INST = 48;
	localparam int FILL     = 4;	// Cycles from IF to WB
	localparam int MAX_WAIT = 10;	// Cycles per wait before giving up
	localparam logic [31:0] NOP  = 32'h0000_0013;	// ADDI x0, x0, 0
	localparam logic [31:0] SEED = 32'h8210b3ca;

	logic               CLK100MHZ;
	logic               arst_n;
	logic               imem_we;
	logic [IMEM_AW-1:0] imem_addr;
	logic [XLEN-1:0]    imem_data;
	logic [PC_W-1:0]    if_pc, id_pc, exe_pc, mem_pc, wb_pc;
	logic               wb_wr_en;
	logic [REG_AW-1:0]  wb_rd;
	logic [XLEN-1:0]    wb_data;

	logic [31:0]     lfsr_state;
	logic [31:0]     prog [NUM_INST];
	logic [31:0]     ref_regs [32];	// Architectural model state
	logic [31:0]     ref_dmem [1 << DMEM_AW];
	int              step;	// Falling edges since the first active clock edge
	logic [PC_W-1:0] prev_if, prev_id, prev_exe, prev_mem;

	`include "tb_model.svh"

	top #(.IMEM_AW(IMEM_AW), .DMEM_AW(DMEM_AW)) dut (
		.CLK100MHZ(CLK100MHZ), .arst_n(arst_n),
		.imem_we(imem_we), .imem_addr(imem_addr), .imem_data(imem_data),
		.if_pc(if_pc), .id_pc(id_pc), .exe_pc(exe_pc), .mem_pc(mem_pc), .wb_pc(wb_pc),
		.wb_wr_en(wb_wr_en), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	initial CLK100MHZ = 1'b0;
	always #50 CLK100MHZ = ~CLK100MHZ;	// 100 ns period

	////////////////////////////////////////////////////////////////////////////
	// Failure reporting
	////////////////////////////////////////////////////////////////////////////
	task automatic stop_with_failure();
		$display("Some tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic value_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		$display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
		stop_with_failure();
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Cycle stepping
	////////////////////////////////////////////////////////////////////////////

	// Next falling edge; each stage PC is the one before it a cycle ago
	task automatic next_cycle();
		@(negedge CLK100MHZ);
		step++;
		assert (if_pc == prev_if + PC_W'(4)) else value_mismatch("if_pc", if_pc, prev_if + 4);
		assert (id_pc == prev_if) else value_mismatch("id_pc", id_pc, prev_if);
		assert (exe_pc == prev_id) else value_mismatch("exe_pc", exe_pc, prev_id);
		assert (mem_pc == prev_exe) else value_mismatch("mem_pc", mem_pc, prev_exe);
		assert (wb_pc == prev_mem) else value_mismatch("wb_pc", wb_pc, prev_mem);
		if (step < FILL) begin	// Still filling, only bubbles in WB
			assert (wb_wr_en === 1'b0) else value_mismatch("wb_wr_en", wb_wr_en, 0);
		end
		prev_if  = if_pc;
		prev_id  = id_pc;
		prev_exe = exe_pc;
		prev_mem = mem_pc;
	endtask

	// Posedge sampling, arst_n only moves on falling edges
	task automatic wait_reset_release();
		int waited;
		waited = 0;
		do begin
			@(posedge CLK100MHZ);
			waited++;
			if (waited > NUM_INST + 16) begin
				$display("Timeout: reset was never released");
				stop_with_failure();
			end
		end while (arst_n !== 1'b1);
	endtask

	task automatic wait_retire(input int k);
		int waited;
		waited = 0;
		do begin
			next_cycle();
			waited++;
			if (waited > MAX_WAIT) begin
				$display("Timeout: instruction %0d never reached writeback", k);
				stop_with_failure();
			end
		end while (!(step >= FILL && wb_pc == PC_W'(4 * k)));
		assert (step == k + FILL) else value_mismatch("retire cycle", step, k + FILL);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////
	initial begin
		arst_n     = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_data  = '0;
		lfsr_state = SEED;
		make_program();
		for (int k = 0; k < NUM_INST; k++) begin	// Load while the core sits in reset
			@(negedge CLK100MHZ);
			imem_we   = 1'b1;
			imem_addr = IMEM_AW'(k);
			imem_data = prog[k];
		end
		@(negedge CLK100MHZ);
		imem_we = 1'b0;
		repeat (4) @(negedge CLK100MHZ);	// Four more reset cycles after the load
		arst_n = 1'b1;
	end

	// Compare process, one retirement per cycle
	initial begin
		logic        exp_wr_en;
		logic [4:0]  exp_rd;
		logic [31:0] exp_data;
		foreach (ref_regs[i]) ref_regs[i] = '0;
		foreach (ref_dmem[i]) ref_dmem[i] = '0;
		wait_reset_release();
		step     = 0;	// Reset state, all PCs zero before this edge
		prev_if  = '0;
		prev_id  = '0;
		prev_exe = '0;
		prev_mem = '0;
		for (int k = 0; k < NUM_INST; k++) begin
			wait_retire(k);
			ref_step(prog[k], exp_wr_en, exp_rd, exp_data);
			assert (wb_wr_en === exp_wr_en)
				else value_mismatch("wb_wr_en", wb_wr_en, exp_wr_en);
			if (exp_wr_en) begin	// rd and data mean nothing for a bubble or SW
				assert (wb_rd === exp_rd) else value_mismatch("wb_rd", wb_rd, exp_rd);
				assert (wb_data === exp_data)
					else value_mismatch("wb_data", wb_data, exp_data);
			end
		end
		$display("All tests passed");
		$finish;
	end

endmodule

// ==== verilog/core_pkg.sv ====
package core_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////
	localparam int PC_W   = 12;	// Byte address of an instruction
	localparam int XLEN   = 32;	// Data path width
	localparam int REG_AW = 5;	// x0..x31

	// Major opcodes of the supported subset
	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011,	// ADDI only
		OP     = 7'b0110011,	// R-type ALU
		LUI    = 7'b0110111,
		LOAD   = 7'b0000011,	// LW only
		STORE  = 7'b0100011	// SW only
	} opcode_e;

	// ADD is zero so that a cleared payload is a harmless add
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_OR    = 4'd3,
		ALU_XOR   = 4'd4,
		ALU_SLT   = 4'd5,	// Signed compare
		ALU_PASSB = 4'd6	// Operand B straight through, for LUI
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_LOAD = 2'd1
	} wb_sel_e;

	////////////////////////////////////////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////////////////////////////////////////
	typedef struct packed {
		logic [PC_W-1:0] pc;
		logic [XLEN-1:0] inst;
	} if_id_t;

	typedef struct packed {
		logic [PC_W-1:0]   pc;
		logic [XLEN-1:0]   rs1_val;	// Regfile values, before forwarding
		logic [XLEN-1:0]   rs2_val;
		logic [REG_AW-1:0] rs1_idx;
		logic [REG_AW-1:0] rs2_idx;
		logic [XLEN-1:0]   imm;
		logic [REG_AW-1:0] rd;
		alu_op_e           alu_op;
		logic              sel_b;	// 1 = immediate as operand B
		logic              dm_write;
		logic              wr_en;
		wb_sel_e           wb_sel;
	} id_exe_t;

	typedef struct packed {
		logic [PC_W-1:0]   pc;
		logic [XLEN-1:0]   alu_out;	// Result, or address for LW/SW
		logic [XLEN-1:0]   store_data;
		logic [REG_AW-1:0] rd;
		logic              dm_write;
		logic              wr_en;
		wb_sel_e           wb_sel;
	} exe_mem_t;

	typedef struct packed {
		logic [PC_W-1:0]   pc;
		logic [XLEN-1:0]   alu_out;
		logic [XLEN-1:0]   load_data;
		logic [REG_AW-1:0] rd;
		logic              wr_en;
		wb_sel_e           wb_sel;
	} mem_wb_t;

endpackage

// ==== verilog/decode.sv ====
`timescale 1ns/1ps

module decode import core_pkg::*; (
	input  logic [XLEN-1:0]   inst,	// From IF/ID
	input  logic [PC_W-1:0]   pc,
	input  logic [XLEN-1:0]   rs1_val,	// Regfile read data
	input  logic [XLEN-1:0]   rs2_val,
	output id_exe_t           id_exe,	// Into ID/EXE
	output logic [REG_AW-1:0] rs1_addr,	// Regfile read addresses
	output logic [REG_AW-1:0] rs2_addr
);
	////////////////////////////////////////////////////////////////////////////
	// Field split and immediates
	////////////////////////////////////////////////////////////////////////////
	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i, imm_s, imm_u;

	assign opcode   = opcode_e'(inst[6:0]);
	assign funct3   = inst[14:12];
	assign funct7   = inst[31:25];
	assign rs1_addr = inst[19:15];
	assign rs2_addr = inst[24:20];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};	// Split across rd slot
	assign imm_u = {inst[31:12], 12'b0};

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		id_exe         = '0;	// Bubble unless matched below
		id_exe.pc      = pc;
		id_exe.rs1_val = rs1_val;
		id_exe.rs2_val = rs2_val;
		id_exe.rs1_idx = rs1_addr;
		id_exe.rs2_idx = rs2_addr;
		id_exe.rd      = inst[11:7];
		id_exe.alu_op  = ALU_ADD;
		id_exe.wb_sel  = WB_ALU;

		case (opcode)
			OP_IMM: begin
				if (funct3 == 3'b000) begin	// ADDI
					id_exe.imm   = imm_i;
					id_exe.sel_b = 1'b1;
					id_exe.wr_en = 1'b1;
				end
			end
			OP: begin
				id_exe.wr_en = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: id_exe.alu_op = ALU_ADD;
					10'b0100000_000: id_exe.alu_op = ALU_SUB;
					10'b0000000_111: id_exe.alu_op = ALU_AND;
					10'b0000000_110: id_exe.alu_op = ALU_OR;
					10'b0000000_100: id_exe.alu_op = ALU_XOR;
					10'b0000000_010: id_exe.alu_op = ALU_SLT;
					default:         id_exe.wr_en  = 1'b0;	// Shifts, SLTU etc.
				endcase
			end
			LUI: begin
				id_exe.imm    = imm_u;
				id_exe.sel_b  = 1'b1;
				id_exe.alu_op = ALU_PASSB;
				id_exe.wr_en  = 1'b1;
			end
			LOAD: begin
				if (funct3 == 3'b010) begin	// LW, address = rs1 + imm
					id_exe.imm    = imm_i;
					id_exe.sel_b  = 1'b1;
					id_exe.wr_en  = 1'b1;
					id_exe.wb_sel = WB_LOAD;
				end
			end
			STORE: begin
				if (funct3 == 3'b010) begin	// SW
					id_exe.imm      = imm_s;
					id_exe.sel_b    = 1'b1;
					id_exe.dm_write = 1'b1;
				end
			end
			default: ;	// Anything else retires as a bubble
		endcase
	end

	a_single_effect: assert final (!(id_exe.dm_write === 1'b1 && id_exe.wr_en === 1'b1))
		else $error("decode: store with register write");

endmodule

// ==== verilog/execute.sv ====
`timescale 1ns/1ps

module execute import core_pkg::*; (
	input  id_exe_t           id_exe,	// From ID/EXE
	input  logic              mem_fwd_en,	// Instruction now in MEM
	input  logic [REG_AW-1:0] mem_fwd_rd,
	input  logic [XLEN-1:0]   mem_fwd_val,
	input  logic              wb_fwd_en,	// Instruction now in WB
	input  logic [REG_AW-1:0] wb_fwd_rd,
	input  logic [XLEN-1:0]   wb_fwd_val,
	output exe_mem_t          exe_mem	// Into EXE/MEM
);
	logic [XLEN-1:0] rs1_fwd, rs2_fwd;	// Register values after forwarding
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] alu_out;

	// Nearest older producer wins; x0 never forwards
	function automatic logic [XLEN-1:0] fwd_sel(input logic [REG_AW-1:0] idx,
		input logic [XLEN-1:0] rf_val);
		if (idx == '0)
			return rf_val;
		if (mem_fwd_en && mem_fwd_rd == idx)
			return mem_fwd_val;
		if (wb_fwd_en && wb_fwd_rd == idx)
			return wb_fwd_val;
		return rf_val;	// Regfile already bypasses the WB write
	endfunction

	always_comb begin
		rs1_fwd = fwd_sel(id_exe.rs1_idx, id_exe.rs1_val);
		rs2_fwd = fwd_sel(id_exe.rs2_idx, id_exe.rs2_val);
		op_b    = id_exe.sel_b ? id_exe.imm : rs2_fwd;
	end

	////////////////////////////////////////////////////////////////////////////
	// ALU
	////////////////////////////////////////////////////////////////////////////
	always_comb begin
		case (id_exe.alu_op)
			ALU_ADD:   alu_out = rs1_fwd + op_b;
			ALU_SUB:   alu_out = rs1_fwd - op_b;
			ALU_AND:   alu_out = rs1_fwd & op_b;
			ALU_OR:    alu_out = rs1_fwd | op_b;
			ALU_XOR:   alu_out = rs1_fwd ^ op_b;
			ALU_SLT:   alu_out = {31'b0, $signed(rs1_fwd) < $signed(op_b)};
			ALU_PASSB: alu_out = op_b;	// LUI
			default:   alu_out = '0;
		endcase
	end

	always_comb begin
		exe_mem.pc         = id_exe.pc;
		exe_mem.alu_out    = alu_out;
		exe_mem.store_data = rs2_fwd;	// SW data sees forwarding too
		exe_mem.rd         = id_exe.rd;
		exe_mem.dm_write   = id_exe.dm_write;
		exe_mem.wr_en      = id_exe.wr_en;
		exe_mem.wb_sel     = id_exe.wb_sel;
	end

	a_op_known: assert final (!(id_exe.wr_en === 1'b1 || id_exe.dm_write === 1'b1)
		|| !$isunknown(id_exe.alu_op))
		else $error("execute: unknown ALU op on a live instruction");

endmodule

// ==== verilog/instmem.sv ====
`timescale 1ns/1ps

module instmem import core_pkg::*; #(
	parameter int IMEM_AW = 6	// Word address bits
) (
	input  logic               clk,
	input  logic               we,	// Load port, used while the core sits in reset
	input  logic [IMEM_AW-1:0] waddr,
	input  logic [XLEN-1:0]    wdata,
	input  logic [PC_W-1:0]    raddr,	// Byte address from the PC
	output logic [XLEN-1:0]    inst
);
	localparam int DEPTH = 1 << IMEM_AW;

	logic [XLEN-1:0] mem [DEPTH] = '{default: '0};	// Power-up contents are bubbles
	logic [PC_W-3:0] widx;	// Word index of the PC

	assign widx = raddr[PC_W-1:2];

	// Combinational fetch, zero past the end of the memory
	always_comb begin
		if (int'(widx) < DEPTH)
			inst = mem[widx[IMEM_AW-1:0]];
		else
			inst = '0;	// All-zero word decodes to a bubble
	end

	always_ff @(posedge clk) begin
		if (we)
			mem[waddr] <= wdata;
	end

endmodule

// ==== verilog/pipereg.sv ====
`timescale 1ns/1ps

module pipereg #(
	parameter type payload_t = logic [31:0]	// Stage payload struct
) (
	input  logic     clk,
	input  logic     arst_n,
	input  payload_t d,
	output payload_t q
);

	// One stage boundary; a cleared payload carries no enables
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			q <= '0;
		else
			q <= d;
	end

	// X anywhere upstream shows up here one cycle later
	a_q_known: assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(q))
		else $error("pipereg: unknown payload");

endmodule

// ==== verilog/regfile.sv ====
`timescale 1ns/1ps

module regfile import core_pkg::*; (
	input  logic              clk,
	input  logic              arst_n,
	input  logic              wr_en,	// From WB
	input  logic [REG_AW-1:0] wr_addr,
	input  logic [XLEN-1:0]   wr_data,
	input  logic [REG_AW-1:0] rs1_addr,	// From ID
	input  logic [REG_AW-1:0] rs2_addr,
	output logic [XLEN-1:0]   rs1_out,
	output logic [XLEN-1:0]   rs2_out
);
	logic [XLEN-1:0] regs [32];

	// Read port with bypass of the write landing this cycle
	function automatic logic [XLEN-1:0] rd_port(input logic [REG_AW-1:0] addr);
		if (wr_en && wr_addr == addr && addr != '0)
			return wr_data;	// WB result not yet in the array
		return regs[addr];
	endfunction

	always_comb begin
		rs1_out = rd_port(rs1_addr);
		rs2_out = rd_port(rs2_addr);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			regs <= '{default: '0};
		end else if (wr_en && wr_addr != '0) begin	// x0 stays zero
			regs[wr_addr] <= wr_data;
		end
	end

endmodule

// ==== verilog/result.sv ====
`timescale 1ns/1ps

module result import core_pkg::*; #(
	parameter int DMEM_AW = 6	// Word address bits
) (
	input  logic              clk,
	input  logic              arst_n,
	input  exe_mem_t          exe_mem,	// MEM stage, from EXE/MEM
	output mem_wb_t           mem_wb_d,	// Into MEM/WB
	input  mem_wb_t           mem_wb_q,	// WB stage, from MEM/WB
	output logic              wb_wr_en,
	output logic [REG_AW-1:0] wb_rd,
	output logic [XLEN-1:0]   wb_data
);
	localparam int DEPTH = 1 << DMEM_AW;

	logic [XLEN-1:0]    dmem [DEPTH];
	logic [DMEM_AW-1:0] widx;	// Word index, low two bits dropped
	logic [XLEN-1:0]    load_data;

	////////////////////////////////////////////////////////////////////////////
	// MEM stage
	////////////////////////////////////////////////////////////////////////////
	assign widx      = exe_mem.alu_out[DMEM_AW+1:2];
	assign load_data = dmem[widx];	// Combinational read

	// Store lands at the edge closing the MEM cycle
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dmem <= '{default: '0};
		end else if (exe_mem.dm_write) begin
			dmem[widx] <= exe_mem.store_data;
		end
	end

	always_comb begin
		mem_wb_d.pc        = exe_mem.pc;
		mem_wb_d.alu_out   = exe_mem.alu_out;
		mem_wb_d.load_data = load_data;
		mem_wb_d.rd        = exe_mem.rd;
		mem_wb_d.wr_en     = exe_mem.wr_en;
		mem_wb_d.wb_sel    = exe_mem.wb_sel;
	end

	////////////////////////////////////////////////////////////////////////////
	// WB stage
	////////////////////////////////////////////////////////////////////////////
	assign wb_wr_en = mem_wb_q.wr_en;
	assign wb_rd    = mem_wb_q.rd;

	always_comb begin
		if (mem_wb_q.wb_sel == WB_LOAD)
			wb_data = mem_wb_q.load_data;
		else
			wb_data = mem_wb_q.alu_out;	// ALU ops and LUI
	end

endmodule

// ==== verilog/top.sv ====
`timescale 1ns/1ps

module top import core_pkg::*; #(
	parameter int IMEM_AW = 6,
	parameter int DMEM_AW = 6
) (
	input  logic               CLK100MHZ,
	input  logic               arst_n,
	input  logic               imem_we,	// Program load, only while in reset
	input  logic [IMEM_AW-1:0] imem_addr,
	input  logic [XLEN-1:0]    imem_data,
	output logic [PC_W-1:0]    if_pc,
	output logic [PC_W-1:0]    id_pc,
	output logic [PC_W-1:0]    exe_pc,
	output logic [PC_W-1:0]    mem_pc,
	output logic [PC_W-1:0]    wb_pc,
	output logic               wb_wr_en,	// Retirement view
	output logic [REG_AW-1:0]  wb_rd,
	output logic [XLEN-1:0]    wb_data
);
	logic [PC_W-1:0]   pc_q;
	logic [XLEN-1:0]   if_inst;
	logic [REG_AW-1:0] rs1_addr, rs2_addr;
	logic [XLEN-1:0]   rs1_val, rs2_val;
	if_id_t            if_id_d, if_id_q;
	id_exe_t           id_exe_d, id_exe_q;
	exe_mem_t          exe_mem_d, exe_mem_q;
	mem_wb_t           mem_wb_d, mem_wb_q;

	////////////////////////////////////////////////////////////////////////////
	// IF
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge CLK100MHZ or negedge arst_n) begin
		if (!arst_n)
			pc_q <= '0;
		else
			pc_q <= pc_q + PC_W'(4);	// No branches, straight-line fetch
	end

	instmem #(.IMEM_AW(IMEM_AW)) u_instmem (
		.clk(CLK100MHZ), .we(imem_we), .waddr(imem_addr), .wdata(imem_data),
		.raddr(pc_q), .inst(if_inst)
	);

	assign if_id_d = '{pc: pc_q, inst: if_inst};

	pipereg #(.payload_t(if_id_t)) u_if_id (
		.clk(CLK100MHZ), .arst_n(arst_n), .d(if_id_d), .q(if_id_q)
	);

	////////////////////////////////////////////////////////////////////////////
	// ID, with the regfile written from WB
	////////////////////////////////////////////////////////////////////////////
	regfile u_regfile (
		.clk(CLK100MHZ), .arst_n(arst_n),
		.wr_en(wb_wr_en), .wr_addr(wb_rd), .wr_data(wb_data),
		.rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
		.rs1_out(rs1_val), .rs2_out(rs2_val)
	);

	decode u_decode (
		.inst(if_id_q.inst), .pc(if_id_q.pc), .rs1_val(rs1_val), .rs2_val(rs2_val),
		.id_exe(id_exe_d), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr)
	);

	pipereg #(.payload_t(id_exe_t)) u_id_exe (
		.clk(CLK100MHZ), .arst_n(arst_n), .d(id_exe_d), .q(id_exe_q)
	);

	// EXE, forwarding from MEM and WB
	execute u_execute (
		.id_exe(id_exe_q),
		.mem_fwd_en(exe_mem_q.wr_en), .mem_fwd_rd(exe_mem_q.rd),
		.mem_fwd_val(exe_mem_q.alu_out),
		.wb_fwd_en(wb_wr_en), .wb_fwd_rd(wb_rd), .wb_fwd_val(wb_data),
		.exe_mem(exe_mem_d)
	);

	pipereg #(.payload_t(exe_mem_t)) u_exe_mem (
		.clk(CLK100MHZ), .arst_n(arst_n), .d(exe_mem_d), .q(exe_mem_q)
	);

	// MEM and WB
	result #(.DMEM_AW(DMEM_AW)) u_result (
		.clk(CLK100MHZ), .arst_n(arst_n), .exe_mem(exe_mem_q),
		.mem_wb_d(mem_wb_d), .mem_wb_q(mem_wb_q),
		.wb_wr_en(wb_wr_en), .wb_rd(wb_rd), .wb_data(wb_data)
	);

	pipereg #(.payload_t(mem_wb_t)) u_mem_wb (
		.clk(CLK100MHZ), .arst_n(arst_n), .d(mem_wb_d), .q(mem_wb_q)
	);

	// Stage PCs for observation
	assign if_pc  = pc_q;
	assign id_pc  = if_id_q.pc;
	assign exe_pc = id_exe_q.pc;
	assign mem_pc = exe_mem_q.pc;
	assign wb_pc  = mem_wb_q.pc;

endmodule

// ==== vlog.f ====
+incdir+tests
verilog/core_pkg.sv
verilog/instmem.sv
verilog/pipereg.sv
verilog/regfile.sv
verilog/decode.sv
verilog/execute.sv
verilog/result.sv
verilog/top.sv
tests/tb_top.sv
